// ==== mini_exec_pipe.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/trap_pkg.sv
verilog/stage_if.sv
verilog/inst_decoder.sv
verilog/stage_reg.sv
verilog/exec_alu.sv
verilog/mini_exec_pipe.sv
sim/tb_mini_exec_pipe.sv

// ==== sim/tb_mini_exec_pipe.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module tb_mini_exec_pipe
    import isa_pkg::*;
    import trap_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   stall;
    logic                   in_valid;
    logic [`DATA_W-1:0]     in_inst;
    logic [`DATA_W-1:0]     in_pc;
    logic [`DATA_W-1:0]     in_src1;
    logic [`DATA_W-1:0]     in_src2;
    logic                   in_ready;
    logic                   out_ready;
    logic                   out_valid;
    logic [`DATA_W-1:0]     out_pc;
    logic [`DATA_W-1:0]     out_result;
    logic [`REG_ADDR_W-1:0] out_rd;
    logic                   out_we;
    except_e                out_except;

    // expected results in acceptance order
    logic [`DATA_W-1:0]     exp_pc[$];
    logic [`DATA_W-1:0]     exp_result[$];
    logic [`REG_ADDR_W-1:0] exp_rd[$];
    logic                   exp_we[$];
    except_e                exp_except[$];

    int          err_count;
    int          check_count;
    bit          bp_random;

    opcode_e op_list [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                             OP_SLL, OP_SRL, OP_ADDI, OP_LUI};

    initial clk = 1'b0;
    always #4 clk = ~clk;

    mini_exec_pipe mini_exec_pipe_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .stall      (stall),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .in_src1    (in_src1),
        .in_src2    (in_src2),
        .in_ready   (in_ready),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_result (out_result),
        .out_rd     (out_rd),
        .out_we     (out_we),
        .out_except (out_except)
    );

    task automatic end_run();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        err_count++;
        $display("timeout while waiting for %s", what);
        end_run();
    endtask

    task automatic check_data(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input logic [`REG_ADDR_W-1:0] got_rd,
                             input logic [`REG_ADDR_W-1:0] want_rd,
                             input logic got_we, input logic want_we);
        check_count++;
        if (got_rd !== want_rd) begin
            err_count++;
            $display("mismatch out_rd: got %h expected %h", got_rd, want_rd);
        end
        if (got_we !== want_we) begin
            err_count++;
            $display("mismatch out_we: got %h expected %h", got_we, want_we);
        end
    endtask

    task automatic check_except(input except_e got, input except_e want);
        check_count++;
        if (got !== want) begin
            err_count++;
            $display("mismatch out_except: got %h expected %h", got, want);
        end
    endtask

    // reference model of decoder and alu
    task automatic push_expected(input logic [`DATA_W-1:0] inst, input logic [`DATA_W-1:0] pc,
                                 input logic [`DATA_W-1:0] s1, input logic [`DATA_W-1:0] s2);
        logic [5:0]             opc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]     res;
        logic                   known;
        except_e                exc;
        opc   = inst[OPC_HI:OPC_LO];
        rd    = inst[RD_HI:RD_LO];
        known = 1'b1;
        res   = '0;
        case (opc)
            OP_ADD:  res = s1 + s2;
            OP_SUB:  res = s1 - s2;
            OP_AND:  res = s1 & s2;
            OP_OR:   res = s1 | s2;
            OP_XOR:  res = s1 ^ s2;
            OP_SLL:  res = s1 << s2[4:0];
            OP_SRL:  res = s1 >> s2[4:0];
            OP_ADDI: res = s1 + {{(`DATA_W-16){inst[15]}}, inst[15:0]};
            OP_LUI:  res = {inst[15:0], {(`DATA_W-16){1'b0}}};
            default: known = 1'b0;
        endcase
        if (pc[1:0] != 2'b00) begin
            exc = EXC_MISALIGNED_PC;
        end else if (!known) begin
            exc = EXC_ILLEGAL_INST;
        end else begin
            exc = EXC_NONE;
        end
        if (exc != EXC_NONE) begin
            res = '0;
        end
        exp_pc.push_back(pc);
        exp_result.push_back(res);
        exp_rd.push_back(rd);
        exp_we.push_back((rd != '0) && (exc == EXC_NONE));
        exp_except.push_back(exc);
    endtask

    // output side scoreboard
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_pc.size() == 0) begin
                err_count++;
                $display("output with pc %h arrived but no result was expected", out_pc);
            end else begin
                check_data("out_pc", out_pc, exp_pc.pop_front());
                check_data("out_result", out_result, exp_result.pop_front());
                check_reg(out_rd, exp_rd.pop_front(), out_we, exp_we.pop_front());
                check_except(out_except, exp_except.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (bp_random) begin
            out_ready <= 1'($urandom_range(0, 1));
        end
    end

    function automatic logic [`DATA_W-1:0] rand_inst(input logic [5:0] opc);
        return {opc, 5'($urandom()), 5'($urandom()), 16'($urandom())};
    endfunction

    function automatic logic [`DATA_W-1:0] rand_pc();
        return `DATA_W'($urandom()) & {{(`DATA_W-2){1'b1}}, 2'b00};
    endfunction

    function automatic opcode_e rand_op();
        return op_list[$urandom_range(0, 8)];
    endfunction

    // call right after a rising edge
    task automatic send_item(input logic [`DATA_W-1:0] inst, input logic [`DATA_W-1:0] pc,
                             input logic [`DATA_W-1:0] s1, input logic [`DATA_W-1:0] s2);
        int n;
        n = 0;
        in_valid <= 1'b1;
        in_inst  <= inst;
        in_pc    <= pc;
        in_src1  <= s1;
        in_src2  <= s2;
        @(posedge clk);
        while (!in_ready) begin
            if (n > WAIT_LIMIT) begin
                timeout_abort("in_ready");
            end
            @(posedge clk);
            n++;
        end
        push_expected(inst, pc, s1, s2);
    endtask

    task automatic drive_idle();
        in_valid <= 1'b0;
    endtask

    task automatic send_random(input int count);
        repeat (count) begin
            send_item(rand_inst(rand_op()), rand_pc(), $urandom(), $urandom());
        end
        drive_idle();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_pc.size() != 0) begin
            if (n > WAIT_LIMIT) begin
                timeout_abort("outstanding results to drain");
            end
            @(posedge clk);
            n++;
        end
    endtask

    // valid rises after edge t+PIPE_STAGES-1, so it is seen at the edge after
    task automatic check_latency();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                timeout_abort("out_valid");
            end
        end while (!out_valid);
        check_count++;
        if (n != `PIPE_STAGES) begin
            err_count++;
            $display("result arrived %0d cycles after acceptance, expected %0d",
                     n - 1, `PIPE_STAGES - 1);
        end
    endtask

    task automatic opcode_sweep();
        foreach (op_list[i]) begin
            send_item(rand_inst(op_list[i]), rand_pc(), $urandom(), $urandom());
            drive_idle();
            check_latency();
            wait_drain();
        end
    endtask

    task automatic backpressure_run();
        logic [`DATA_W-1:0] inst;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] s1;
        logic [`DATA_W-1:0] s2;
        bp_random = 1'b1;
        send_random(20);
        wait_drain();
        bp_random = 1'b0;
        @(posedge clk);
        out_ready <= 1'b0;
        send_random(`PIPE_STAGES);
        // one more item has to wait at the input
        inst = rand_inst(rand_op());
        pc   = rand_pc();
        s1   = $urandom();
        s2   = $urandom();
        in_valid <= 1'b1;
        in_inst  <= inst;
        in_pc    <= pc;
        in_src1  <= s1;
        in_src2  <= s2;
        @(posedge clk);
        check_count++;
        if (in_ready !== 1'b0) begin
            err_count++;
            $display("in_ready stayed high with all stages full");
        end
        out_ready <= 1'b1;
        send_item(inst, pc, s1, s2);
        drive_idle();
        wait_drain();
    endtask

    task automatic stall_hold();
        fork
            send_random(10);
            begin
                repeat (3) @(posedge clk);
                stall <= 1'b1;
                repeat (5) begin
                    @(posedge clk);
                    check_count++;
                    if ((out_valid !== 1'b0) || (in_ready !== 1'b0)) begin
                        err_count++;
                        $display("out_valid or in_ready high during stall");
                    end
                end
                stall <= 1'b0;
            end
        join
        wait_drain();
    endtask

    task automatic flush_midstream();
        out_ready <= 1'b0;
        send_random(`PIPE_STAGES);
        @(posedge clk);
        flush <= 1'b1;
        // flushed items must never show up
        exp_pc.delete();
        exp_result.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_except.delete();
        @(posedge clk);
        flush     <= 1'b0;
        out_ready <= 1'b1;
        repeat (2 * `PIPE_STAGES + 2) @(posedge clk);
        send_random(5);
        wait_drain();
    endtask

    task automatic exception_cases();
        send_item({6'h3f, 5'd4, 5'd0, 16'h1234}, 32'h0000_0100, $urandom(), $urandom());
        send_item({OP_ADD, 5'd7, 5'd0, 16'h0}, 32'h0000_1002, $urandom(), $urandom());
        send_item({6'h3e, 5'd9, 5'd0, 16'h0}, 32'h0000_2001, $urandom(), $urandom());
        send_item({OP_ADD, 5'd0, 5'd0, 16'h0}, 32'h0000_3000, $urandom(), $urandom());
        send_item({OP_ADDI, 5'd3, 5'd0, 16'hfff0}, 32'h0000_4000, 32'h10, $urandom());
        drive_idle();
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h8a35513c));
        err_count   = 0;
        check_count = 0;
        bp_random   = 1'b0;
        rst       <= 1'b1;
        flush     <= 1'b0;
        stall     <= 1'b0;
        in_valid  <= 1'b0;
        in_inst   <= '0;
        in_pc     <= '0;
        in_src1   <= '0;
        in_src2   <= '0;
        out_ready <= 1'b1;
        repeat (2) @(posedge clk);
        // one reset edge clears every stage
        check_count++;
        if (out_valid !== 1'b0) begin
            err_count++;
            $display("out_valid not low after the first reset edge");
        end
        repeat (6) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        opcode_sweep();
        send_random(20);
        wait_drain();
        backpressure_run();
        stall_hold();
        flush_midstream();
        exception_cases();
        repeat (4) @(posedge clk);
        end_run();
    end

endmodule

// ==== verilog/exec_alu.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module exec_alu
    import isa_pkg::*;
    import trap_pkg::*;
(
    stage_if.i                     ex,
    output logic [`DATA_W-1:0]     result,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic                   wr_en,
    output except_e                except_code,
    output logic [`DATA_W-1:0]     pc
);

    logic [4:0] shamt;

    // shift amount from low bits of operand2
    assign shamt = ex.operand2[4:0];

    always_comb begin
        case (ex.ex_op)
            EX_ADD:  result = ex.operand1 + ex.operand2;
            EX_SUB:  result = ex.operand1 - ex.operand2;
            EX_AND:  result = ex.operand1 & ex.operand2;
            EX_OR:   result = ex.operand1 | ex.operand2;
            EX_XOR:  result = ex.operand1 ^ ex.operand2;
            EX_SLL:  result = ex.operand1 << shamt;
            EX_SRL:  result = ex.operand1 >> shamt;
            // immediate already sits in the upper half
            EX_LUI:  result = ex.operand2;
            default: result = '0;
        endcase
    end

    assign wr_addr     = ex.rw_addr;
    assign wr_en       = ex.rw_en;
    assign except_code = ex.except_code;
    assign pc          = ex.pc;

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module inst_decoder
    import isa_pkg::*;
    import trap_pkg::*;
(
    input  logic [`DATA_W-1:0] inst,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] src1,
    input  logic [`DATA_W-1:0] src2,
    stage_if.o                 ex
);

    opcode_e                opcode;
    logic [`REG_ADDR_W-1:0] rd;
    logic [15:0]            imm16;
    logic [`DATA_W-1:0]     imm_sext;
    logic [`DATA_W-1:0]     imm_upper;
    logic                   misaligned;
    logic                   illegal;
    ex_op_e                 op_dec;
    except_e                exc;

    assign opcode     = opcode_e'(inst[OPC_HI:OPC_LO]);
    assign rd         = inst[RD_HI:RD_LO];
    assign imm16      = inst[IMM_HI:IMM_LO];
    assign imm_sext   = {{(`DATA_W-16){imm16[15]}}, imm16};
    assign imm_upper  = {imm16, {(`DATA_W-16){1'b0}}};
    assign misaligned = |pc[1:0];

    // opcode to alu operation
    always_comb begin
        illegal = 1'b0;
        case (opcode)
            OP_ADD:  op_dec = EX_ADD;
            OP_SUB:  op_dec = EX_SUB;
            OP_AND:  op_dec = EX_AND;
            OP_OR:   op_dec = EX_OR;
            OP_XOR:  op_dec = EX_XOR;
            OP_SLL:  op_dec = EX_SLL;
            OP_SRL:  op_dec = EX_SRL;
            OP_ADDI: op_dec = EX_ADD;
            OP_LUI:  op_dec = EX_LUI;
            default: begin
                op_dec  = EX_NOP;
                illegal = 1'b1;
            end
        endcase
    end

    // misaligned pc wins over illegal opcode
    always_comb begin
        if (misaligned) begin
            exc = EXC_MISALIGNED_PC;
        end else if (illegal) begin
            exc = EXC_ILLEGAL_INST;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_comb begin
        ex.inst     = inst;
        ex.pc       = pc;
        ex.operand1 = src1;
        case (opcode)
            OP_ADDI: ex.operand2 = imm_sext;
            OP_LUI:  ex.operand2 = imm_upper;
            default: ex.operand2 = src2;
        endcase
        ex.ex_op       = (exc == EXC_NONE) ? op_dec : EX_NOP;
        ex.rw_addr     = rd;
        ex.rw_en       = (rd != '0) && (exc == EXC_NONE);
        ex.except_code = exc;
    end

endmodule

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    // major opcode in inst[31:26]
    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SLL  = 6'h06,
        OP_SRL  = 6'h07,
        OP_ADDI = 6'h08,
        OP_LUI  = 6'h09
    } opcode_e;

    typedef enum logic [3:0] {
        EX_NOP = 4'd0,
        EX_ADD = 4'd1,
        EX_SUB = 4'd2,
        EX_AND = 4'd3,
        EX_OR  = 4'd4,
        EX_XOR = 4'd5,
        EX_SLL = 4'd6,
        EX_SRL = 4'd7,
        EX_LUI = 4'd8
    } ex_op_e;

    // instruction word fields
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 26;
    localparam int RD_HI  = 25;
    localparam int RD_LO  = 21;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

endpackage

// ==== verilog/mini_exec_pipe.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module mini_exec_pipe
    import trap_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   in_valid,
    input  logic [`DATA_W-1:0]     in_inst,
    input  logic [`DATA_W-1:0]     in_pc,
    input  logic [`DATA_W-1:0]     in_src1,
    input  logic [`DATA_W-1:0]     in_src2,
    output logic                   in_ready,
    input  logic                   out_ready,
    output logic                   out_valid,
    output logic [`DATA_W-1:0]     out_pc,
    output logic [`DATA_W-1:0]     out_result,
    output logic [`REG_ADDR_W-1:0] out_rd,
    output logic                   out_we,
    output except_e                out_except
);

    // entry 0 is the decoder, entry k the output of stage k
    stage_if sif [`PIPE_STAGES+1] ();

    logic [`PIPE_STAGES:0] valid_chain;
    logic [`PIPE_STAGES:0] ready_chain;

    assign valid_chain[0]            = in_valid;
    assign ready_chain[`PIPE_STAGES] = out_ready;

    inst_decoder inst_decoder_i (
        .inst (in_inst),
        .pc   (in_pc),
        .src1 (in_src1),
        .src2 (in_src2),
        .ex   (sif[0])
    );

    genvar k;
    generate
        for (k = 0; k < `PIPE_STAGES; k++) begin : g_stage
            stage_reg stage_reg_i (
                .clk      (clk),
                .rst      (rst),
                .flush    (flush),
                .stall    (stall),
                .ls_valid (valid_chain[k]),
                .ns_ready (ready_chain[k+1]),
                .ts_valid (valid_chain[k+1]),
                .ts_ready (ready_chain[k]),
                .id_info  (sif[k]),
                .ex_info  (sif[k+1])
            );
        end
    endgenerate

    exec_alu exec_alu_i (
        .ex          (sif[`PIPE_STAGES]),
        .result      (out_result),
        .wr_addr     (out_rd),
        .wr_en       (out_we),
        .except_code (out_except),
        .pc          (out_pc)
    );

    // handshake ends of the chain
    assign in_ready  = ready_chain[0];
    assign out_valid = valid_chain[`PIPE_STAGES];

endmodule

// ==== verilog/pipe_macros.svh ====
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// datapath width
`define DATA_W 32

// register file address width
`define REG_ADDR_W 5

// number of stage registers between decoder and alu, 1 to 8
`define PIPE_STAGES 3

`endif

// ==== verilog/stage_if.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

// one execute bundle between two pipeline stages
interface stage_if
    import isa_pkg::*;
    import trap_pkg::*;
();
    logic [`DATA_W-1:0]     inst;
    logic [`DATA_W-1:0]     pc;
    logic [`DATA_W-1:0]     operand1;
    logic [`DATA_W-1:0]     operand2;
    ex_op_e                 ex_op;
    logic [`REG_ADDR_W-1:0] rw_addr;
    logic                   rw_en;
    except_e                except_code;

    // consumer side
    modport i (
        input inst,
        input pc,
        input operand1,
        input operand2,
        input ex_op,
        input rw_addr,
        input rw_en,
        input except_code
    );

    // producer side
    modport o (
        output inst,
        output pc,
        output operand1,
        output operand2,
        output ex_op,
        output rw_addr,
        output rw_en,
        output except_code
    );
endinterface

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg
    import isa_pkg::*;
    import trap_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic stall,
    input  logic ls_valid,
    input  logic ns_ready,
    output logic ts_valid,
    output logic ts_ready,
    stage_if.i   id_info,
    stage_if.o   ex_info
);

    logic valid_q;
    logic load;

    // empty or draining, and never while the pipe is stalled
    assign ts_ready = !stall && (!valid_q || ns_ready);
    assign ts_valid = !stall && valid_q;
    assign load     = ls_valid && ts_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (ts_ready) begin
            valid_q <= ls_valid;
        end
    end

    // bundle stays put unless a new one is taken
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_info.inst        <= '0;
            ex_info.pc          <= '0;
            ex_info.operand1    <= '0;
            ex_info.operand2    <= '0;
            ex_info.ex_op       <= EX_NOP;
            ex_info.rw_addr     <= '0;
            ex_info.rw_en       <= 1'b0;
            ex_info.except_code <= EXC_NONE;
        end else if (load) begin
            ex_info.inst        <= id_info.inst;
            ex_info.pc          <= id_info.pc;
            ex_info.operand1    <= id_info.operand1;
            ex_info.operand2    <= id_info.operand2;
            ex_info.ex_op       <= id_info.ex_op;
            ex_info.rw_addr     <= id_info.rw_addr;
            ex_info.rw_en       <= id_info.rw_en;
            ex_info.except_code <= id_info.except_code;
        end
    end

endmodule

// ==== verilog/trap_pkg.sv ====
package trap_pkg;

    // exception codes carried with each bundle
    typedef enum logic [1:0] {
        EXC_NONE          = 2'd0,
        EXC_ILLEGAL_INST  = 2'd1,
        EXC_MISALIGNED_PC = 2'd2
    } except_e;

endpackage
